/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run backEndTb, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f project.f --top-module backEndTb -Mdir obj_dir
	./obj_dir/VbackEndTb | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* project.f */
+incdir+source
source/backEndPkg.sv
source/dataMemory.sv
source/execStage.sv
source/mulDivUnit.sv
source/exMemReg.sv
source/memStage.sv
source/backEndTop.sv
tb/backEndTb.sv

/* source/backEndPkg.sv */
`include "backEnd_settings.svh"

package backEndPkg;

    // ---------------------------------------------------------------------------
    // basic vectors
    // ---------------------------------------------------------------------------
    typedef logic [`DATA_WIDTH-1:0]    dataWord;     // one data value.
    typedef logic [`REG_IDX_WIDTH-1:0] regIdx;       // register index.
    typedef logic [3:0]                byteEnable;   // one bit per byte lane.

    // ---------------------------------------------------------------------------
    // operation encodings
    // ---------------------------------------------------------------------------
    // shifts move operand A by the amount in the low bits of operand B
    typedef enum logic [3:0] {
        aluAdd  = 4'd0,
        aluSub  = 4'd1,
        aluAnd  = 4'd2,
        aluOr   = 4'd3,
        aluXor  = 4'd4,
        aluNor  = 4'd5,
        aluSlt  = 4'd6,
        aluSltu = 4'd7,
        aluSll  = 4'd8,
        aluSrl  = 4'd9,
        aluSra  = 4'd10
    } aluOp;

    typedef enum logic [2:0] {
        loadNone = 3'd0,
        loadLw   = 3'd1,
        loadLh   = 3'd2,
        loadLhu  = 3'd3,
        loadLb   = 3'd4,
        loadLbu  = 3'd5
    } loadOpt;

    typedef enum logic [1:0] {
        storeNone = 2'd0,
        storeSw   = 2'd1,
        storeSh   = 2'd2,
        storeSb   = 2'd3
    } storeOpt;

    typedef enum logic [3:0] {
        mdNone  = 4'd0,
        mdMult  = 4'd1,
        mdMultu = 4'd2,
        mdDiv   = 4'd3,
        mdDivu  = 4'd4,
        mdMthi  = 4'd5,
        mdMtlo  = 4'd6,
        mdMfhi  = 4'd7,
        mdMflo  = 4'd8
    } mdOp;

    typedef enum logic [1:0] {
        mdIdle    = 2'd0,
        mdMultRun = 2'd1,
        mdDivRun  = 2'd2
    } mdState;

    // ---------------------------------------------------------------------------
    // stage bundles
    // ---------------------------------------------------------------------------
    typedef struct packed {
        logic    valid;
        aluOp    aluFunc;
        dataWord opA;
        dataWord opB;
        regIdx   dest;
        logic    regWrite;
        loadOpt  loadSel;
        storeOpt storeSel;
        mdOp     mdSel;
    } issueInstr;

    typedef struct packed {
        logic    valid;
        logic    regWrite;
        regIdx   dest;
        dataWord result;       // ALU value, HI/LO read, or memory address.
        dataWord storeData;
        loadOpt  loadSel;
        storeOpt storeSel;
    } exMemBundle;

    typedef struct packed {
        logic    valid;
        regIdx   dest;
        dataWord data;
    } wbPort;

endpackage

/* source/backEndTop.sv */
`timescale 1ns/1ps
`include "backEnd_settings.svh"

module backEndTop
    import backEndPkg::*;
(
    input  logic      Clk,
    input  logic      Reset,
    input  issueInstr instr,
    output logic      stall,
    output wbPort     wb
);

    logic       busy;
    logic       mdStart;
    mdOp        mdOpSel;
    dataWord    hi;
    dataWord    lo;
    exMemBundle exBundle;
    exMemBundle memBundle;

    // ---------------------------------------------------------------------------
    // execute and the multiply/divide unit
    // ---------------------------------------------------------------------------
    execStage execute (
        .instr   (instr),
        .busy    (busy),
        .hi      (hi),
        .lo      (lo),
        .stall   (stall),
        .mdStart (mdStart),
        .mdOpOut (mdOpSel),
        .exOut   (exBundle)
    );

    mulDivUnit mulDiv (
        .Clk   (Clk),
        .Reset (Reset),
        .start (mdStart),
        .op    (mdOpSel),
        .a     (instr.opA),     // operands straight from the issued instruction.
        .b     (instr.opB),
        .busy  (busy),
        .hi    (hi),
        .lo    (lo)
    );

    // ---------------------------------------------------------------------------
    // EX/MEM and the memory stage
    // ---------------------------------------------------------------------------
    exMemReg exMem (
        .Clk    (Clk),
        .Reset  (Reset),
        .stall  (stall),
        .exIn   (exBundle),
        .memOut (memBundle)
    );

    memStage memory (
        .Clk   (Clk),
        .Reset (Reset),
        .memIn (memBundle),
        .wb    (wb)
    );

endmodule

/* source/backEnd_settings.svh */
`ifndef BACKEND_SETTINGS_SVH
`define BACKEND_SETTINGS_SVH

// ---------------------------------------------------------------------------
// datapath widths
// ---------------------------------------------------------------------------
`define DATA_WIDTH      32      // data word width.
`define REG_IDX_WIDTH   5       // register file index width.

// ---------------------------------------------------------------------------
// data RAM and multiply/divide timing
// ---------------------------------------------------------------------------
`define MEM_WORDS       256     // default data RAM depth in words.
`define MULT_CYCLES     6       // busy cycles of mult and multu.
`define DIV_CYCLES      33      // busy cycles of div and divu, 32 steps plus the fixup.

`endif

/* source/dataMemory.sv */
`timescale 1ns/1ps
`include "backEnd_settings.svh"

module dataMemory #(
    parameter int memWords = `MEM_WORDS
) (
    input  logic                        Clk,
    input  logic [$clog2(memWords)-1:0] addr,
    input  logic                        writeEn,
    input  logic [3:0]                  byteEn,
    input  logic [`DATA_WIDTH-1:0]      writeData,
    output logic [`DATA_WIDTH-1:0]      readData
);

    logic [3:0][7:0] ram [memWords];     // four byte lanes per word.

    always_ff @(posedge Clk) begin
        if (writeEn) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (byteEn[lane]) begin
                    ram[addr][lane] <= writeData[lane*8 +: 8];
                end
            end
        end
    end

    // reads see the word as of the last edge
    assign readData = ram[addr];

endmodule

/* source/exMemReg.sv */
`timescale 1ns/1ps
`include "backEnd_settings.svh"

module exMemReg
    import backEndPkg::*;
(
    input  logic       Clk,
    input  logic       Reset,
    input  logic       stall,
    input  exMemBundle exIn,
    output exMemBundle memOut
);

    exMemBundle bubble;

    // a bubble keeps the payload but can neither write a register nor store
    always_comb begin
        bubble          = exIn;
        bubble.valid    = 1'b0;
        bubble.regWrite = 1'b0;
        bubble.storeSel = storeNone;
    end

    always_ff @(posedge Clk or negedge Reset) begin
        if (!Reset) begin
            memOut <= '0;
        end else if (stall) begin
            memOut <= bubble;     // held instruction goes in later.
        end else begin
            memOut <= exIn;
        end
    end

endmodule

/* source/execStage.sv */
`timescale 1ns/1ps
`include "backEnd_settings.svh"

module execStage
    import backEndPkg::*;
(
    input  issueInstr  instr,
    input  logic       busy,
    input  dataWord    hi,
    input  dataWord    lo,
    output logic       stall,
    output logic       mdStart,
    output mdOp        mdOpOut,
    output exMemBundle exOut
);

    localparam int shiftWidth = $clog2(`DATA_WIDTH);

    dataWord               aluResult;
    logic                  accepted;
    logic                  startsUnit;
    logic [shiftWidth-1:0] shamt;

    // ---------------------------------------------------------------------------
    // hazard on the multiply/divide unit
    // ---------------------------------------------------------------------------
    // any HI/LO access waits until the running operation has finished
    assign stall    = instr.valid && busy && (instr.mdSel != mdNone);
    assign accepted = instr.valid && !stall;

    always_comb begin
        case (instr.mdSel)
            mdMult, mdMultu, mdDiv, mdDivu, mdMthi, mdMtlo: startsUnit = 1'b1;
            default:                                        startsUnit = 1'b0;
        endcase
    end

    assign mdStart = accepted && startsUnit;   // one pulse per accepted op.
    assign mdOpOut = instr.mdSel;

    // ---------------------------------------------------------------------------
    // ALU
    // ---------------------------------------------------------------------------
    assign shamt = instr.opB[shiftWidth-1:0];

    always_comb begin
        case (instr.aluFunc)
            aluAdd:  aluResult = instr.opA + instr.opB;
            aluSub:  aluResult = instr.opA - instr.opB;
            aluAnd:  aluResult = instr.opA & instr.opB;
            aluOr:   aluResult = instr.opA | instr.opB;
            aluXor:  aluResult = instr.opA ^ instr.opB;
            aluNor:  aluResult = ~(instr.opA | instr.opB);
            aluSlt:  aluResult = dataWord'($signed(instr.opA) < $signed(instr.opB));
            aluSltu: aluResult = dataWord'(instr.opA < instr.opB);
            aluSll:  aluResult = instr.opA << shamt;
            aluSrl:  aluResult = instr.opA >> shamt;
            aluSra:  aluResult = $signed(instr.opA) >>> shamt;
            default: aluResult = '0;
        endcase
    end

    // ---------------------------------------------------------------------------
    // EX/MEM bundle
    // ---------------------------------------------------------------------------
    always_comb begin
        exOut.valid     = instr.valid;         // the register turns stalls into bubbles.
        exOut.regWrite  = instr.regWrite;
        exOut.dest      = instr.dest;
        exOut.storeData = instr.opB;
        exOut.loadSel   = instr.loadSel;
        exOut.storeSel  = instr.storeSel;
        case (instr.mdSel)
            mdMfhi:  exOut.result = hi;
            mdMflo:  exOut.result = lo;
            default: exOut.result = aluResult;
        endcase
    end

endmodule

/* source/memStage.sv */
`timescale 1ns/1ps
`include "backEnd_settings.svh"

module memStage
    import backEndPkg::*;
(
    input  logic       Clk,
    input  logic       Reset,
    input  exMemBundle memIn,
    output wbPort      wb
);

    localparam int addrWidth = $clog2(`MEM_WORDS);

    logic [addrWidth-1:0] wordAddr;
    logic [1:0]           byteOff;
    logic                 writeEn;
    byteEnable            byteEn;
    dataWord              writeData;
    dataWord              readData;
    logic [7:0]           laneByte;
    logic [15:0]          laneHalf;
    dataWord              loadValue;

    assign wordAddr = memIn.result[addrWidth+1:2];
    assign byteOff  = memIn.result[1:0];
    assign writeEn  = memIn.valid && (memIn.storeSel != storeNone);

    // ---------------------------------------------------------------------------
    // store lanes
    // ---------------------------------------------------------------------------
    always_comb begin
        case (memIn.storeSel)
            storeSh: begin
                byteEn    = byteOff[1] ? 4'b1100 : 4'b0011;
                writeData = {2{memIn.storeData[15:0]}};
            end
            storeSb: begin
                byteEn    = 4'b0001 << byteOff;
                writeData = {4{memIn.storeData[7:0]}};
            end
            default: begin
                byteEn    = 4'b1111;            // word store.
                writeData = memIn.storeData;
            end
        endcase
    end

    dataMemory #(
        .memWords (`MEM_WORDS)
    ) dataRam (
        .Clk       (Clk),
        .addr      (wordAddr),
        .writeEn   (writeEn),
        .byteEn    (byteEn),
        .writeData (writeData),
        .readData  (readData)
    );

    // ---------------------------------------------------------------------------
    // load extraction and extension
    // ---------------------------------------------------------------------------
    assign laneByte = readData[{byteOff, 3'b000} +: 8];
    assign laneHalf = byteOff[1] ? readData[31:16] : readData[15:0];   // little endian.

    always_comb begin
        case (memIn.loadSel)
            loadLw:  loadValue = readData;
            loadLh:  loadValue = {{16{laneHalf[15]}}, laneHalf};
            loadLhu: loadValue = {16'b0, laneHalf};
            loadLb:  loadValue = {{24{laneByte[7]}}, laneByte};
            loadLbu: loadValue = {24'b0, laneByte};
            default: loadValue = memIn.result;   // not a load.
        endcase
    end

    always_ff @(posedge Clk or negedge Reset) begin
        if (!Reset) begin
            wb <= '0;
        end else begin
            wb.valid <= memIn.valid && memIn.regWrite;
            wb.dest  <= memIn.dest;
            wb.data  <= loadValue;
        end
    end

endmodule

/* source/mulDivUnit.sv */
`timescale 1ns/1ps
`include "backEnd_settings.svh"

module mulDivUnit
    import backEndPkg::*;
(
    input  logic    Clk,
    input  logic    Reset,
    input  logic    start,
    input  mdOp     op,
    input  dataWord a,
    input  dataWord b,
    output logic    busy,
    output dataWord hi,
    output dataWord lo
);

    localparam int cntWidth = $clog2(`DIV_CYCLES + 1);

    mdState                          state;
    logic [cntWidth-1:0]             count;      // remaining busy cycles.
    logic [2*`DATA_WIDTH-1:0]        product;
    logic signed [2*`DATA_WIDTH-1:0] signedProd;
    logic [2*`DATA_WIDTH-1:0]        unsignedProd;
    dataWord                         divisor;
    dataWord                         quotient;
    dataWord                         remainder;
    logic                            negQuot;
    logic                            negRem;
    logic                            isSigned;
    logic                            lastCycle;
    logic [`DATA_WIDTH:0]            trial;      // shifted remainder minus divisor.

    assign busy         = (state != mdIdle);
    assign lastCycle    = (count == cntWidth'(1));
    assign isSigned     = (op == mdMult) || (op == mdDiv);
    assign signedProd   = $signed(a) * $signed(b);
    assign unsignedProd = {`DATA_WIDTH'(0), a} * {`DATA_WIDTH'(0), b};
    assign trial        = {remainder, quotient[`DATA_WIDTH-1]} - {1'b0, divisor};

    // ---------------------------------------------------------------------------
    // sequencing and HI/LO
    // ---------------------------------------------------------------------------
    always_ff @(posedge Clk or negedge Reset) begin
        if (!Reset) begin
            state <= mdIdle;
            count <= '0;
            hi    <= '0;
            lo    <= '0;
        end else begin
            case (state)
                mdIdle: begin
                    if (start) begin
                        case (op)
                            mdMult, mdMultu: begin
                                state <= mdMultRun;
                                count <= cntWidth'(`MULT_CYCLES);
                            end
                            mdDiv, mdDivu: begin
                                state <= mdDivRun;
                                count <= cntWidth'(`DIV_CYCLES);
                            end
                            mdMthi:  hi <= a;    // direct moves take one cycle.
                            mdMtlo:  lo <= a;
                            default: state <= mdIdle;
                        endcase
                    end
                end
                mdMultRun: begin
                    count <= count - cntWidth'(1);
                    if (lastCycle) begin
                        state <= mdIdle;
                        hi    <= product[2*`DATA_WIDTH-1:`DATA_WIDTH];
                        lo    <= product[`DATA_WIDTH-1:0];
                    end
                end
                mdDivRun: begin
                    count <= count - cntWidth'(1);
                    if (lastCycle) begin
                        state <= mdIdle;
                        if (divisor != '0) begin   // divide by zero keeps HI and LO.
                            lo <= negQuot ? -quotient : quotient;
                            hi <= negRem ? -remainder : remainder;
                        end
                    end
                end
                default: state <= mdIdle;
            endcase
        end
    end

    // ---------------------------------------------------------------------------
    // operand capture and restoring division steps
    // ---------------------------------------------------------------------------
    always_ff @(posedge Clk) begin
        if (start && (state == mdIdle)) begin
            product   <= isSigned ? signedProd : unsignedProd;
            divisor   <= (isSigned && b[`DATA_WIDTH-1]) ? -b : b;
            quotient  <= (isSigned && a[`DATA_WIDTH-1]) ? -a : a;
            remainder <= '0;
            negQuot   <= isSigned && (a[`DATA_WIDTH-1] ^ b[`DATA_WIDTH-1]);
            negRem    <= isSigned && a[`DATA_WIDTH-1];   // remainder follows the dividend.
        end else if ((state == mdDivRun) && !lastCycle) begin
            if (!trial[`DATA_WIDTH]) begin
                remainder <= trial[`DATA_WIDTH-1:0];
                quotient  <= {quotient[`DATA_WIDTH-2:0], 1'b1};
            end else begin
                remainder <= {remainder[`DATA_WIDTH-2:0], quotient[`DATA_WIDTH-1]};
                quotient  <= {quotient[`DATA_WIDTH-2:0], 1'b0};
            end
        end
    end

endmodule

/* tb/backEndTb.sv */
`timescale 1ns/1ps
`include "backEnd_settings.svh"

module backEndTb
    import backEndPkg::*;
;

    typedef struct {
        int      due;
        regIdx   dest;
        dataWord data;
    } expectEntry;

    logic       Clk = 1'b0;
    logic       Reset;
    issueInstr  instr;
    logic       stall;
    wbPort      wb;

    int         cycle = 0;          // rising edges seen so far.
    int         errors = 0;
    int         timeouts = 0;
    int         stallCount;         // stalled cycles of the last issued instruction.
    expectEntry expQ[$];
    logic [7:0] shadow [256];       // first 64 words of the data RAM.
    dataWord    shHi = '0;
    dataWord    shLo = '0;

    backEndTop UUT (
        .Clk   (Clk),
        .Reset (Reset),
        .instr (instr),
        .stall (stall),
        .wb    (wb)
    );

    always #4 Clk = ~Clk;

    always @(posedge Clk) cycle <= cycle + 1;

    function automatic void reportFail(string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        errors++;
    endfunction

    // ---------------------------------------------------------------------------
    // reference model
    // ---------------------------------------------------------------------------
    function automatic dataWord aluResult(aluOp f, dataWord a, dataWord b);
        case (f)
            aluAdd:  return a + b;
            aluSub:  return a - b;
            aluAnd:  return a & b;
            aluOr:   return a | b;
            aluXor:  return a ^ b;
            aluNor:  return ~(a | b);
            aluSlt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            aluSltu: return (a < b) ? 32'd1 : 32'd0;
            aluSll:  return a << b[4:0];
            aluSrl:  return a >> b[4:0];
            aluSra:  return dataWord'($signed(a) >>> b[4:0]);
            default: return '0;
        endcase
    endfunction

    function automatic void mulDivUpdate(mdOp op, dataWord a, dataWord b);
        longint sa;
        longint sb;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        case (op)
            mdMult:  {shHi, shLo} = sa * sb;
            mdMultu: {shHi, shLo} = {32'h0, a} * {32'h0, b};
            mdDiv: begin
                if (b != '0) begin             // divide by zero keeps HI and LO.
                    shLo = dataWord'(sa / sb);
                    shHi = dataWord'(sa % sb);
                end
            end
            mdDivu: begin
                if (b != '0) begin
                    shLo = a / b;
                    shHi = a % b;
                end
            end
            mdMthi:  shHi = a;
            mdMtlo:  shLo = a;
            default: begin
            end
        endcase
    endfunction

    function automatic void writeShadow(storeOpt sel, logic [7:0] addr, dataWord data);
        int n;
        n = (sel == storeSw) ? 4 : (sel == storeSh) ? 2 : 1;
        for (int i = 0; i < n; i++) begin
            shadow[addr + 8'(i)] = data[8*i +: 8];   // little endian lanes.
        end
    endfunction

    function automatic dataWord readShadow(loadOpt sel, logic [7:0] addr);
        logic [7:0]  b;
        logic [15:0] h;
        dataWord     w;
        b = shadow[addr];
        h = {shadow[{addr[7:1], 1'b1}], shadow[{addr[7:1], 1'b0}]};
        w = {shadow[{addr[7:2], 2'd3}], shadow[{addr[7:2], 2'd2}],
             shadow[{addr[7:2], 2'd1}], shadow[{addr[7:2], 2'd0}]};
        case (sel)
            loadLw:  return w;
            loadLh:  return {{16{h[15]}}, h};
            loadLhu: return {16'h0, h};
            loadLb:  return {{24{b[7]}}, b};
            loadLbu: return {24'h0, b};
            default: return '0;
        endcase
    endfunction

    // ---------------------------------------------------------------------------
    // instruction builders
    // ---------------------------------------------------------------------------
    function automatic issueInstr aluInstr(aluOp f, dataWord a, dataWord b, regIdx dest,
                                           logic valid, logic wr);
        issueInstr ins;
        ins          = '0;
        ins.valid    = valid;
        ins.aluFunc  = f;
        ins.opA      = a;
        ins.opB      = b;
        ins.dest     = dest;
        ins.regWrite = wr;
        return ins;
    endfunction

    function automatic issueInstr storeInstr(storeOpt sel, logic [7:0] addr, dataWord value);
        issueInstr ins;
        ins          = aluInstr(aluAdd, dataWord'(addr) - value, value, '0, 1'b1, 1'b0);
        ins.storeSel = sel;                      // A + B lands on addr.
        return ins;
    endfunction

    function automatic issueInstr loadInstr(loadOpt sel, logic [7:0] addr, regIdx dest);
        issueInstr ins;
        ins         = aluInstr(aluAdd, dataWord'(addr), '0, dest, 1'b1, 1'b1);
        ins.loadSel = sel;
        return ins;
    endfunction

    function automatic issueInstr mdInstr(mdOp op, dataWord a, dataWord b, regIdx dest);
        issueInstr ins;
        ins       = aluInstr(aluAdd, a, b, dest, 1'b1, (op == mdMfhi) || (op == mdMflo));
        ins.mdSel = op;
        return ins;
    endfunction

    // ---------------------------------------------------------------------------
    // issue one instruction, holding it while stalled
    // ---------------------------------------------------------------------------
    task automatic issue(input issueInstr ins);
        int         waited;
        dataWord    result;
        expectEntry entry;
        waited     = 0;
        stallCount = 0;
        if (timeouts == 0) begin
            @(negedge Clk);
            instr = ins;
            #1;
            while (stall && waited < 100) begin
                @(negedge Clk);
                #1;
                waited++;
            end
            if (stall) begin
                $display("timeout at %0t ns: stall stayed high for 100 cycles", $time);
                timeouts++;
                instr = '0;
            end else if (ins.valid) begin
                stallCount = waited;
                result = aluResult(ins.aluFunc, ins.opA, ins.opB);
                case (ins.mdSel)
                    mdMfhi:  result = shHi;
                    mdMflo:  result = shLo;
                    default: mulDivUpdate(ins.mdSel, ins.opA, ins.opB);
                endcase
                if (ins.storeSel != storeNone) writeShadow(ins.storeSel, result[7:0], ins.opB);
                if (ins.loadSel != loadNone) result = readShadow(ins.loadSel, result[7:0]);
                if (ins.regWrite) begin
                    entry.due  = cycle + 2;      // accept edge, then EX/MEM, then write-back.
                    entry.dest = ins.dest;
                    entry.data = result;
                    expQ.push_back(entry);
                end
            end
        end
    endtask

    task automatic mdPair(input mdOp op, input dataWord a, input dataWord b);
        int expectStall;
        expectStall = (op == mdMult || op == mdMultu) ? `MULT_CYCLES :
                      (op == mdDiv || op == mdDivu) ? `DIV_CYCLES : 0;
        issue(mdInstr(op, a, b, 5'd0));
        assert (stallCount == 0) else reportFail("multiply/divide op was stalled");
        issue(mdInstr(mdMfhi, '0, '0, 5'd1));
        assert (stallCount == expectStall)
            else reportFail($sformatf("mfhi stalled %0d cycles, expected %0d",
                                      stallCount, expectStall));
        issue(mdInstr(mdMflo, '0, '0, 5'd2));
        assert (stallCount == 0) else reportFail("mflo stalled after mfhi");
    endtask

    // write-back port is stable around the falling edge
    always @(negedge Clk) begin
        if (!Reset) begin
            assert (!wb.valid && !stall) else reportFail("stall or write-back during reset");
        end else if (expQ.size() != 0 && expQ[0].due == cycle) begin
            assert (wb.valid && wb.dest == expQ[0].dest && wb.data == expQ[0].data)
                else reportFail($sformatf("write-back v%0b r%0d %h, expected r%0d %h",
                                          wb.valid, wb.dest, wb.data,
                                          expQ[0].dest, expQ[0].data));
            void'(expQ.pop_front());
        end else begin
            assert (!wb.valid) else reportFail($sformatf("unexpected write-back to r%0d",
                                                         wb.dest));
        end
    end

    // ---------------------------------------------------------------------------
    // stimulus
    // ---------------------------------------------------------------------------
    initial begin
        dataWord    a;
        logic [7:0] addr;
        storeOpt    ssel;
        loadOpt     lsel;
        int         waited;
        void'($urandom(25));
        Reset = 1'b0;
        instr = mdInstr(mdMfhi, '0, '0, 5'd1);   // a HI read stalls only on a busy unit.
        repeat (5) @(negedge Clk);
        instr = '0;
        Reset = 1'b1;

        issue(mdInstr(mdMfhi, '0, '0, 5'd1));    // HI and LO leave reset as zero.
        assert (stallCount == 0) else reportFail("mfhi stalled just after reset");
        issue(mdInstr(mdMflo, '0, '0, 5'd2));

        repeat (200) begin                      // ALU stream.
            a = $urandom;
            issue(aluInstr(aluOp'($urandom_range(0, 10)), a,
                           ($urandom_range(0, 3) == 0) ? a : $urandom,
                           regIdx'($urandom_range(0, 31)), 1'b1, 1'b1));
        end

        for (int w = 0; w < 64; w++) begin
            issue(storeInstr(storeSw, 8'(w * 4), $urandom));
        end
        repeat (150) begin
            ssel = storeOpt'($urandom_range(1, 3));
            addr = 8'($urandom_range(0, 255));
            if (ssel == storeSw) addr[1:0] = 2'b00;
            if (ssel == storeSh) addr[0] = 1'b0;
            issue(storeInstr(ssel, addr, $urandom));
            lsel = loadOpt'($urandom_range(1, 5));
            addr[1:0] = 2'($urandom_range(0, 3));
            if (lsel == loadLw) addr[1:0] = 2'b00;
            if (lsel == loadLh || lsel == loadLhu) addr[0] = 1'b0;
            issue(loadInstr(lsel, addr, regIdx'($urandom_range(1, 31))));
        end

        mdPair(mdMult, -32'sd7, 32'sd9);
        mdPair(mdMultu, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
        repeat (6) begin
            mdPair(mdMult, $urandom, $urandom);
            mdPair(mdMultu, $urandom, $urandom);
            mdPair(mdDiv, $urandom, dataWord'(int'($urandom_range(0, 200)) - 100));
            mdPair(mdDivu, $urandom, $urandom_range(1, 70000));
        end
        mdPair(mdDiv, -32'sd100, 32'sd7);
        mdPair(mdDiv, 32'sd100, -32'sd7);
        mdPair(mdDiv, 32'h8000_0000, 32'hFFFF_FFFF);
        mdPair(mdDiv, 32'd12345, '0);            // HI and LO must survive.
        mdPair(mdDivu, 32'd99, '0);
        mdPair(mdMthi, $urandom, '0);
        mdPair(mdMtlo, $urandom, '0);

        repeat (20) begin                       // nothing may reach write-back.
            issue(aluInstr(aluOr, $urandom, $urandom, 5'd3, 1'b0, 1'b1));
            issue(aluInstr(aluXor, $urandom, $urandom, 5'd4, 1'b1, 1'b0));
            issue(storeInstr(storeSb, 8'($urandom_range(0, 255)), $urandom));
        end
        issue(aluInstr(aluAdd, '0, '0, '0, 1'b0, 1'b0));

        waited = 0;
        while (expQ.size() != 0 && waited < 100) begin
            @(negedge Clk);
            waited++;
        end
        if (expQ.size() != 0) begin
            $display("timeout: %0d write-backs never arrived", expQ.size());
            timeouts++;
        end
        repeat (3) @(negedge Clk);

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
